//--- dv/bp_asserts.sv
module bp_asserts
	import bp_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      lookup_ready,
	input logic      pred_valid,
	input logic      pred_ready,
	input logic      pred_taken,
	input pred_src_e pred_src
);

	// Response stage comes out of reset empty
	assert property (@(posedge clk) !rst_n |=> !pred_valid)
		else $error("pred_valid high in the cycle after reset");

	assert property (@(posedge clk) disable iff (!rst_n)
		pred_valid && !pred_ready |=> pred_valid && $stable(pred_taken) && $stable(pred_src))
		else $error("response changed while stalled");

	assert property (@(posedge clk) disable iff (!rst_n)
		lookup_ready == (!pred_valid || pred_ready))
		else $error("lookup_ready does not follow the response stage");

endmodule

bind tournament_chooser bp_asserts u_asserts
(
	.clk         (clk),
	.rst_n       (rst_n),
	.lookup_ready(lookup_ready),
	.pred_valid  (pred_valid),
	.pred_ready  (pred_ready),
	.pred_taken  (pred_taken),
	.pred_src    (pred_src)
);

//--- dv/bp_tb.sv
module bp_tb
	import bp_pkg::*;
();

	localparam int TIMEOUT = 200;

	logic        clk;
	logic        rst_n;
	logic        lookup_valid;
	logic        lookup_ready;
	logic [31:0] lookup_pc;
	branch_op_e  lookup_op;
	logic        lookup_imm_neg;
	logic        pred_valid;
	logic        pred_ready;
	logic        pred_taken;
	pred_src_e   pred_src;
	logic        upd_valid;
	logic [31:0] upd_pc;
	branch_op_e  upd_op;
	logic        upd_taken;

	// Model state; local table indexed by {op, history}
	ctr_t        m_glob   [1024] = '{default: CTR_INIT};
	ctr_t        m_loc    [NUM_OPS * 32] = '{default: CTR_INIT};
	logic [4:0]  m_ghr = '0;
	logic [4:0]  m_lhr    [NUM_OPS] = '{default: '0};
	logic [2:0]  m_choice [NUM_OPS] = '{default: '0};
	logic [2:0]  exp_q    [$];
	int          errors = 0;
	int          checks = 0;
	int          base_err = 0;
	int          base_chk = 0;
	int          stall_pct = 0;
	logic        hung = 1'b0;

	branch_predictor_top u_dut (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic ctr_t bump(ctr_t c, logic tk);
		if (tk)
			return (c == 2'd3) ? c : c + 2'd1;
		return (c == 2'd0) ? c : c - 2'd1;
	endfunction

	// Expected {taken, src} for a lookup against the current model state
	function automatic logic [2:0] predict(logic [31:0] pc, branch_op_e op, logic neg);
		logic use_g;
		ctr_t c;
		use_g = m_choice[op][2];
		c = use_g ? m_glob[pc[11:2] ^ {5'd0, m_ghr}] : m_loc[{op, m_lhr[op]}];
		if (c == 2'd1 || c == 2'd2)
			return {neg, SRC_STATIC};
		return {c >= 2'd2, use_g ? SRC_GLOBAL : SRC_LOCAL};
	endfunction

	function automatic void apply_update(logic [31:0] pc, branch_op_e op, logic tk);
		logic [9:0] gi;
		logic [7:0] li;
		logic       g_ok;
		logic       l_ok;
		gi   = pc[11:2] ^ {5'd0, m_ghr};
		li   = {op, m_lhr[op]};
		g_ok = (m_glob[gi] >= 2'd2) == tk;
		l_ok = (m_loc[li] >= 2'd2) == tk;
		if (g_ok && !l_ok && m_choice[op] != 3'd7)
			m_choice[op] = m_choice[op] + 3'd1;
		else if (!g_ok && l_ok && m_choice[op] != 3'd0)
			m_choice[op] = m_choice[op] - 3'd1;
		m_glob[gi] = bump(m_glob[gi], tk);
		m_loc[li]  = bump(m_loc[li], tk);
		m_ghr      = {m_ghr[3:0], tk};
		m_lhr[op]  = {m_lhr[op][3:0], tk};
	endfunction

	task automatic check_taken(input logic got, input logic want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("** Error at %0t: pred_taken %b, expected %b", $time, got, want);
		end
	endtask

	task automatic check_src(input pred_src_e got, input pred_src_e want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("** Error at %0t: pred_src %s, expected %s", $time, got.name(), want.name());
		end
	endtask

	// Lookup held until accepted; the update goes out with the first try only
	task automatic drive(input logic look, input logic upd, input logic [31:0] pc,
		input branch_op_e op, input logic neg, input logic tk);
		logic [2:0] e;
		logic       done;
		int         n;
		done = 1'b0;
		for (n = 0; n < TIMEOUT && !done && !hung; n++)
		begin
			@(negedge clk);
			pred_ready     = $urandom_range(99) >= stall_pct;
			lookup_valid   = look;
			lookup_pc      = pc;
			lookup_op      = op;
			lookup_imm_neg = neg;
			upd_valid      = upd && n == 0;
			upd_pc         = pc;
			upd_op         = op;
			upd_taken      = tk;
			#1;
			done = !look || lookup_ready;
			e    = predict(pc, op, neg);
			if (upd_valid)
				apply_update(pc, op, tk);
			@(posedge clk);
			if (look && done)
				exp_q.push_back(e);
		end
		if (!done && !hung)
		begin
			hung = 1'b1;
			$display("Timeout at %0t: lookup was never accepted", $time);
		end
	endtask

	task automatic end_test(input string name);
		int n;
		@(negedge clk);
		lookup_valid = 1'b0;
		upd_valid    = 1'b0;
		pred_ready   = 1'b1;
		for (n = 0; n < TIMEOUT && (exp_q.size() != 0 || pred_valid); n++)
			@(negedge clk);
		if (n == TIMEOUT)
		begin
			hung = 1'b1;
			$display("Timeout at %0t: %s left responses pending", $time, name);
		end
		$display("%s: %0d checks, %0d errors", name, checks - base_chk, errors - base_err);
		base_chk = checks;
		base_err = errors;
	endtask

	// Each response handed over is matched against the oldest expectation
	initial
	begin
		logic [2:0] e;
		forever
		begin
			@(negedge clk);
			#1;
			if (rst_n === 1'b1 && pred_valid && pred_ready)
			begin
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("Response at %0t arrived with no lookup pending", $time);
				end
				else
				begin
					e = exp_q.pop_front();
					check_taken(pred_taken, e[2]);
					check_src(pred_src, pred_src_e'(e[1:0]));
				end
			end
		end
	end

	initial
	begin
		logic [31:0] pc;
		branch_op_e  op;
		void'($urandom(32'h5f0d));
		rst_n          = 1'b0;
		lookup_valid   = 1'b0;
		lookup_pc      = '0;
		lookup_op      = BEQ;
		lookup_imm_neg = 1'b0;
		pred_ready     = 1'b1;
		upd_valid      = 1'b0;
		upd_pc         = '0;
		upd_op         = BEQ;
		upd_taken      = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		drive(1'b1, 1'b0, 32'h100, BEQ, 1'b0, 1'b0);
		drive(1'b1, 1'b0, 32'h104, BNE, 1'b1, 1'b0);
		drive(1'b1, 1'b0, 32'h2f0, BGEU, 1'b1, 1'b0);
		end_test("reset lookups");

		// Loop branch walks through the weak states
		repeat (10)
		begin
			drive(1'b0, 1'b1, 32'h400, BLT, 1'b1, 1'b1);
			drive(1'b1, 1'b0, 32'h400, BLT, 1'b1, 1'b0);
			drive(1'b1, 1'b0, 32'h400, BLT, 1'b0, 1'b0);
		end
		end_test("loop training");

		repeat (120)
		begin
			pc = 32'h1000 + ($urandom_range(15) << 2);
			op = branch_op_e'($urandom_range(NUM_OPS - 1));
			// Not-taken updates away from the test pcs clear the global history
			repeat (5)
				drive(1'b0, 1'b1, 32'h400, BEQ, 1'b0, 1'b0);
			drive(1'b0, 1'b1, pc, op, 1'b0, pc[2] ^ pc[4] ^ ($urandom_range(7) == 0));
			drive(1'b1, 1'b0, pc, op, $urandom_range(1) == 1, 1'b0);
		end
		end_test("random updates");

		stall_pct = 60;
		repeat (40)
		begin
			pc = 32'h1000 + ($urandom_range(15) << 2);
			op = branch_op_e'($urandom_range(NUM_OPS - 1));
			drive($urandom_range(3) != 0, $urandom_range(1) == 1, pc, op, pc[3],
				$urandom_range(1) == 1);
		end
		stall_pct = 0;
		end_test("back-pressure");

		repeat (12)
			drive(1'b1, 1'b1, 32'h800, BGE, 1'b1, 1'b1);
		end_test("same-cycle update");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0 && !hung)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- flist.f
verilog/bp_pkg.sv
verilog/bp_update_if.sv
verilog/global_history_predictor.sv
verilog/local_history_predictor.sv
verilog/tournament_chooser.sv
verilog/branch_predictor_top.sv
dv/bp_asserts.sv
dv/bp_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module bp_tb -f flist.f -o bp_sim \
	&& ./obj_dir/bp_sim | tee /dev/stderr | grep -x "All tests passed" > /dev/null \
	|| { echo "simulation failed"; exit 1; }

//--- verilog/bp_pkg.sv
package bp_pkg;

	typedef enum logic [2:0]
	{
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU
	} branch_op_e;

	typedef enum logic [1:0]
	{
		SRC_GLOBAL,
		SRC_LOCAL,
		SRC_STATIC
	} pred_src_e;

	// 0 strong NT, 1 weak NT, 2 weak T, 3 strong T
	typedef logic [1:0] ctr_t;

	localparam ctr_t CTR_INIT = 2'd0;
	localparam ctr_t CTR_MAX  = 2'd3;
	localparam int   NUM_OPS  = 6;

	function automatic logic ctr_taken(ctr_t c);
		return c[1];
	endfunction

	function automatic logic ctr_weak(ctr_t c);
		return c[1] ^ c[0];
	endfunction

	// One saturating step toward the outcome
	function automatic ctr_t ctr_next(ctr_t c, logic taken);
		ctr_t n;
		n = c;
		if (taken && c != CTR_MAX)
			n = c + 2'd1;
		else if (!taken && c != 2'd0)
			n = c - 2'd1;
		return n;
	endfunction

endpackage

//--- verilog/bp_update_if.sv
interface bp_update_if
	import bp_pkg::*;
();
	logic        valid;
	logic [31:0] pc;
	branch_op_e  op;
	logic        taken;

	modport src
	(
		output valid,
		output pc,
		output op,
		output taken
	);

	modport sink
	(
		input valid,
		input pc,
		input op,
		input taken
	);

endinterface

//--- verilog/branch_predictor_top.sv
module branch_predictor_top
	import bp_pkg::*;
#(
	parameter int GHR_WIDTH    = 5,
	parameter int LHR_WIDTH    = 5,
	parameter int CHOICE_WIDTH = 3
)
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        lookup_valid,
	output logic        lookup_ready,
	input  logic [31:0] lookup_pc,
	input  branch_op_e  lookup_op,
	input  logic        lookup_imm_neg,

	output logic        pred_valid,
	input  logic        pred_ready,
	output logic        pred_taken,
	output pred_src_e   pred_src,

	input  logic        upd_valid,
	input  logic [31:0] upd_pc,
	input  branch_op_e  upd_op,
	input  logic        upd_taken
);

	ctr_t glob_look_ctr;
	ctr_t glob_upd_ctr;
	ctr_t loc_look_ctr;
	ctr_t loc_upd_ctr;

	bp_update_if u_upd ();

	assign u_upd.valid = upd_valid;
	assign u_upd.pc    = upd_pc;
	assign u_upd.op    = upd_op;
	assign u_upd.taken = upd_taken;

	global_history_predictor #(
		.GHR_WIDTH(GHR_WIDTH)
	) u_glob (
		.clk      (clk),
		.rst_n    (rst_n),
		.lookup_pc(lookup_pc),
		.upd      (u_upd.sink),
		.look_ctr (glob_look_ctr),
		.upd_ctr  (glob_upd_ctr)
	);

	local_history_predictor #(
		.LHR_WIDTH(LHR_WIDTH)
	) u_loc (
		.clk      (clk),
		.rst_n    (rst_n),
		.lookup_op(lookup_op),
		.upd      (u_upd.sink),
		.look_ctr (loc_look_ctr),
		.upd_ctr  (loc_upd_ctr)
	);

	tournament_chooser #(
		.CHOICE_WIDTH(CHOICE_WIDTH)
	) u_chooser (
		.clk           (clk),
		.rst_n         (rst_n),
		.lookup_valid  (lookup_valid),
		.lookup_ready  (lookup_ready),
		.lookup_op     (lookup_op),
		.lookup_imm_neg(lookup_imm_neg),
		.pred_valid    (pred_valid),
		.pred_ready    (pred_ready),
		.pred_taken    (pred_taken),
		.pred_src      (pred_src),
		.glob_look_ctr (glob_look_ctr),
		.glob_upd_ctr  (glob_upd_ctr),
		.loc_look_ctr  (loc_look_ctr),
		.loc_upd_ctr   (loc_upd_ctr),
		.upd           (u_upd.sink)
	);

endmodule

//--- verilog/global_history_predictor.sv
module global_history_predictor
	import bp_pkg::*;
#(
	parameter int GHR_WIDTH = 5
)
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] lookup_pc,
	bp_update_if.sink   upd,
	output ctr_t        look_ctr,
	output ctr_t        upd_ctr
);

	localparam int IDX_W      = 10;
	localparam int TABLE_SIZE = 1 << IDX_W;

	ctr_t                 ctr_tab [TABLE_SIZE];
	logic [GHR_WIDTH-1:0] ghr;
	logic [IDX_W-1:0]     ghr_ext;
	logic [IDX_W-1:0]     look_idx;
	logic [IDX_W-1:0]     upd_idx;

	// History is narrower than the index, pad with zeros
	assign ghr_ext = IDX_W'(ghr);

	assign look_idx = lookup_pc[11:2] ^ ghr_ext;
	assign upd_idx  = upd.pc[11:2] ^ ghr_ext;

	assign look_ctr = ctr_tab[look_idx];
	assign upd_ctr  = ctr_tab[upd_idx];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < TABLE_SIZE; i++)
				ctr_tab[i] <= CTR_INIT;
			ghr <= '0;
		end
		else if (upd.valid)
		begin
			ctr_tab[upd_idx] <= ctr_next(upd_ctr, upd.taken);
			// Newest outcome enters at bit 0
			ghr <= {ghr[GHR_WIDTH-2:0], upd.taken};
		end
	end

endmodule

//--- verilog/local_history_predictor.sv
module local_history_predictor
	import bp_pkg::*;
#(
	parameter int LHR_WIDTH = 5
)
(
	input  logic       clk,
	input  logic       rst_n,
	input  branch_op_e lookup_op,
	bp_update_if.sink  upd,
	output ctr_t       look_ctr,
	output ctr_t       upd_ctr
);

	localparam int OP_W       = $bits(branch_op_e);
	localparam int IDX_W      = OP_W + LHR_WIDTH;
	localparam int TABLE_SIZE = NUM_OPS * (1 << LHR_WIDTH);

	ctr_t                 ctr_tab [TABLE_SIZE];
	logic [LHR_WIDTH-1:0] lhr     [NUM_OPS];
	logic [IDX_W-1:0]     look_idx;
	logic [IDX_W-1:0]     upd_idx;

	// Kind selects the block of counters, its history the entry within
	assign look_idx = {lookup_op, lhr[lookup_op]};
	assign upd_idx  = {upd.op, lhr[upd.op]};

	assign look_ctr = ctr_tab[look_idx];
	assign upd_ctr  = ctr_tab[upd_idx];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < TABLE_SIZE; i++)
				ctr_tab[i] <= CTR_INIT;
			for (int k = 0; k < NUM_OPS; k++)
				lhr[k] <= '0;
		end
		else if (upd.valid)
		begin
			ctr_tab[upd_idx] <= ctr_next(upd_ctr, upd.taken);
			lhr[upd.op]      <= {lhr[upd.op][LHR_WIDTH-2:0], upd.taken};
		end
	end

endmodule

//--- verilog/tournament_chooser.sv
module tournament_chooser
	import bp_pkg::*;
#(
	parameter int CHOICE_WIDTH = 3
)
(
	input  logic       clk,
	input  logic       rst_n,

	input  logic       lookup_valid,
	output logic       lookup_ready,
	input  branch_op_e lookup_op,
	input  logic       lookup_imm_neg,

	output logic       pred_valid,
	input  logic       pred_ready,
	output logic       pred_taken,
	output pred_src_e  pred_src,

	input  ctr_t       glob_look_ctr,
	input  ctr_t       glob_upd_ctr,
	input  ctr_t       loc_look_ctr,
	input  ctr_t       loc_upd_ctr,

	bp_update_if.sink  upd
);

	localparam logic [CHOICE_WIDTH-1:0] CHOICE_MAX = '1;

	logic [CHOICE_WIDTH-1:0] choice [NUM_OPS];
	logic                    use_global;
	ctr_t                    sel_ctr;
	logic                    next_taken;
	pred_src_e               next_src;
	logic                    lookup_fire;
	logic                    glob_ok;
	logic                    loc_ok;

	// MSB of the choice counter picks gshare
	assign use_global = choice[lookup_op][CHOICE_WIDTH-1];
	assign sel_ctr    = use_global ? glob_look_ctr : loc_look_ctr;

	always_comb
	begin
		if (ctr_weak(sel_ctr))
		begin
			// Backward taken, forward not taken
			next_taken = lookup_imm_neg;
			next_src   = SRC_STATIC;
		end
		else
		begin
			next_taken = ctr_taken(sel_ctr);
			next_src   = use_global ? SRC_GLOBAL : SRC_LOCAL;
		end
	end

	assign lookup_ready = !pred_valid || pred_ready;
	assign lookup_fire  = lookup_valid && lookup_ready;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pred_valid <= 1'b0;
		else if (lookup_fire)
			pred_valid <= 1'b1;
		else if (pred_ready)
			pred_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (lookup_fire)
		begin
			pred_taken <= next_taken;
			pred_src   <= next_src;
		end
	end

	assign glob_ok = ctr_taken(glob_upd_ctr) == upd.taken;
	assign loc_ok  = ctr_taken(loc_upd_ctr) == upd.taken;

	// Move toward whichever component alone was right
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_OPS; i++)
				choice[i] <= '0;
		end
		else if (upd.valid)
		begin
			if (glob_ok && !loc_ok && choice[upd.op] != CHOICE_MAX)
				choice[upd.op] <= choice[upd.op] + 1'b1;
			else if (!glob_ok && loc_ok && choice[upd.op] != '0)
				choice[upd.op] <= choice[upd.op] - 1'b1;
		end
	end

endmodule
